//--- sources.f
src/riscvPkg.sv
src/controlUnit.sv
src/regFile.sv
src/alu.sv
src/immExtend.sv
src/loadStoreAligner.sv
src/busPort.sv
src/riscvCore.sv
test/coreChecker.sv
test/coreTb.sv

//--- run.sh
#!/bin/bash
verilator --binary --timing --assert -j 0 --top-module coreTb -f sources.f -o coreSim \
    && ./obj_dir/coreSim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/coreTb.sv
// RV32I core testbench
`timescale 1ns/1ps

module coreTb;

    localparam int progWords  = 64;
    localparam int numTests   = 6;
    localparam int cycleLimit = numTests * progWords * 22 + 100;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               fetchReq;
    riscvPkg::fetchReqT fetchAddr;
    logic               fetchAck = 1'b0;
    riscvPkg::fetchRspT fetchData = '0;
    logic               dataReq;
    riscvPkg::dataReqT  dataBits;
    logic               dataAck = 1'b0;
    riscvPkg::dataRspT  dataRsp = '0;
    logic               retireValid;
    riscvPkg::retireT   retire;

    logic [31:0] prog [progWords];
    logic [31:0] dataMem [256];
    integer      seed = 53574;
    logic        randomDelays = 1'b1;
    logic        recordRun = 1'b0;
    logic        compareRun = 1'b0;
    logic        testDone;
    logic        timedOut;
    int          passCount;
    int          failCount;
    logic [1:0]  fetchPhase;
    logic [1:0]  fetchWait;
    logic [1:0]  dataPhase;
    logic [1:0]  dataWait;

    riscvCore riscvCore_i (
        .clk, .reset, .fetchReq, .fetchAddr, .fetchAck, .fetchData,
        .dataReq, .dataBits, .dataAck, .dataRsp, .retireValid, .retire
    );

    coreChecker #(.progWords(progWords)) coreChecker_i (
        .clk, .reset, .retireValid, .retire, .prog, .recordRun, .compareRun,
        .cycleLimit(cycleLimit), .testDone, .timedOut, .passCount, .failCount
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [1:0] pickDelay();
        logic [31:0] r;
        r = randWord();
        return randomDelays ? r[1:0] : 2'd0;
    endfunction

    // 0 R, 1 I, 2 LUI/AUIPC, 3 store, 4 load, 5 branch, 6 JAL, 7 JALR, 8 unknown
    function automatic int pickKind(input int test);
        logic [31:0] r;
        int          m;
        r = randWord();
        case (test)
        0: return r[0] ? 1 : 0;
        1: return r % 3;
        2: return r[1] ? (r[0] ? 4 : 3) : 1;
        3: begin
            m = r % 5;
            return (m < 2) ? m : m + 3;
        end
        default: return r % 9;
        endcase
    endfunction

    function automatic logic [31:0] makeInstr(input int kind, input int idx, input int last);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] off;
        logic [31:0] tgt;
        logic [11:0] imm12;
        logic [11:0] mask;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [1:0]  low;
        logic [6:0]  f7;
        r = randWord();
        s = randWord();
        rd = {2'b00, r[2:0]};   // x0..x7 keeps dependencies dense
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3 = r[11:9];
        low = (r[10:9] == 2'b11) ? 2'b10 : r[10:9];
        off = 4 * (1 + (s % (last - idx)));   // Forward target
        mask = low[1] ? 12'hffc : (low[0] ? 12'hffe : 12'hfff);
        imm12 = {2'b00, (r[13] ? s[9:0] : {4'b0, s[5:0]})} & mask;
        case (kind)
        0: begin
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[12]) ? 7'b0100000 : 7'b0;
            return {f7, rs2, rs1, f3, rd, riscvPkg::opR};
        end
        1: begin
            if (f3 == 3'b001) begin
                imm12 = {7'b0, s[4:0]};
            end else if (f3 == 3'b101) begin
                imm12 = {r[12] ? 7'b0100000 : 7'b0, s[4:0]};
            end else begin
                imm12 = s[11:0];
            end
            return {imm12, rs1, f3, rd, riscvPkg::opImm};
        end
        2: return {s[31:12], rd, r[12] ? riscvPkg::opLui : riscvPkg::opAuipc};
        3: return {imm12[11:5], rs2, 5'd0, 1'b0, low, imm12[4:0], riscvPkg::opStore};
        4: return {imm12, 5'd0, (low != 2'b10) && r[12], low, rd, riscvPkg::opLoad};
        5: begin
            if (f3 == 3'b010 || f3 == 3'b011) f3[2] = 1'b1;
            return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscvPkg::opBranch};
        end
        6: return {off[20], off[10:1], off[11], off[19:12], rd, riscvPkg::opJal};
        7: begin
            tgt = off + idx * 4;
            return {tgt[11:0], 5'd0, 3'b000, rd, riscvPkg::opJalr};
        end
        default: return {s[24:0], 7'b0001011};
        endcase
    endfunction

    task automatic buildProgram(input int test);
        for (int i = 0; i < progWords - 1; i++) begin
            prog[i] = makeInstr(pickKind(test), i, progWords - 1);
        end
        prog[progWords - 1] = 32'h0000_006f;   // jal x0, 0
    endtask

    // Instruction memory responder
    always @(posedge clk) begin
        if (reset) begin
            fetchAck <= 1'b0;
            fetchPhase <= 2'd0;
            fetchWait <= 2'd0;
        end else begin
            case (fetchPhase)
            2'd0: if (fetchReq) begin
                fetchWait <= pickDelay();
                fetchPhase <= 2'd1;
            end
            2'd1: if (fetchWait == 2'd0) begin
                fetchData <= prog[fetchAddr[7:2]];
                fetchAck <= 1'b1;
                fetchPhase <= 2'd2;
            end else begin
                fetchWait <= fetchWait - 2'd1;
            end
            2'd2: if (!fetchReq) begin
                fetchWait <= pickDelay();
                fetchPhase <= 2'd3;
            end
            default: if (fetchWait == 2'd0) begin
                fetchAck <= 1'b0;
                fetchPhase <= 2'd0;
            end else begin
                fetchWait <= fetchWait - 2'd1;
            end
            endcase
        end
    end

    // Data memory responder
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) dataMem[i] <= '0;
            dataAck <= 1'b0;
            dataPhase <= 2'd0;
            dataWait <= 2'd0;
        end else begin
            case (dataPhase)
            2'd0: if (dataReq) begin
                dataWait <= pickDelay();
                dataPhase <= 2'd1;
            end
            2'd1: if (dataWait == 2'd0) begin
                if (dataBits.write) begin
                    for (int k = 0; k < 4; k++) begin
                        if (dataBits.byteEn[k]) begin
                            dataMem[dataBits.addr[9:2]][k*8 +: 8] <= dataBits.writeData[k*8 +: 8];
                        end
                    end
                end
                dataRsp <= dataMem[dataBits.addr[9:2]];
                dataAck <= 1'b1;
                dataPhase <= 2'd2;
            end else begin
                dataWait <= dataWait - 2'd1;
            end
            2'd2: if (!dataReq) begin
                dataWait <= pickDelay();
                dataPhase <= 2'd3;
            end
            default: if (dataWait == 2'd0) begin
                dataAck <= 1'b0;
                dataPhase <= 2'd0;
            end else begin
                dataWait <= dataWait - 2'd1;
            end
            endcase
        end
    end

    always @(posedge clk) begin
        if (timedOut) begin
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        for (int t = 0; t < numTests; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            randomDelays <= (t != 4);   // Test 4 runs without ack delay
            recordRun <= (t == 4);
            compareRun <= (t == 5);     // Same program, random delays
            if (t != 5) buildProgram(t);
            repeat (4) @(posedge clk);
            reset <= 1'b0;
            while (!testDone) @(posedge clk);
        end
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && passCount == numTests) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/coreChecker.sv
// RV32I retire checker
`timescale 1ns/1ps

module coreChecker #(
    parameter int progWords = 64
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             retireValid,
    input  riscvPkg::retireT retire,
    input  logic [31:0]      prog [progWords],
    input  logic             recordRun,     // Keep this run's retire sequence
    input  logic             compareRun,    // Replay against the kept sequence
    input  int unsigned      cycleLimit,
    output logic             testDone = 1'b0,
    output logic             timedOut = 1'b0,
    output int               passCount = 0,
    output int               failCount = 0
);

    logic [31:0]      mRegs [32];
    logic [31:0]      mMem [256];
    logic [31:0]      mPc;
    riscvPkg::retireT goldRun [$];
    int               runIdx;
    int               testNo = 1;
    int               testErrors;
    int               retired;
    int unsigned      cycles = 0;

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] loadRef(input logic [2:0] f3, input logic [1:0] off,
                                            input logic [31:0] word);
        logic [31:0] lane;
        lane = word >> {off, 3'b000};
        case (f3)
        3'b000: return {{24{lane[7]}}, lane[7:0]};
        3'b001: return {{16{lane[15]}}, lane[15:0]};
        3'b100: return {24'b0, lane[7:0]};
        3'b101: return {16'b0, lane[15:0]};
        default: return word;
        endcase
    endfunction

    task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch test %0d pc %h: %s expected %h actual %h",
                     testNo, mPc, name, exp, act);
            testErrors++;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit && !timedOut) begin
            $display("run timed out before all tests finished");
            timedOut <= 1'b1;
        end
    end

    always @(posedge clk) begin
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [2:0]  f3;
        logic        wr;
        if (reset) begin
            for (int i = 0; i < 32; i++) mRegs[i] = '0;
            for (int i = 0; i < 256; i++) mMem[i] = '0;
            mPc = riscvPkg::resetPc;
            testErrors = 0;
            retired = 0;
            runIdx = 0;
            if (recordRun) goldRun.delete();
            testDone <= 1'b0;
        end else if (retireValid && !testDone) begin
            ins = prog[mPc[7:2]];
            f3 = ins[14:12];
            a = mRegs[ins[19:15]];
            b = mRegs[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr = 1'b0;
            res = '0;
            nextPc = mPc + 32'd4;
            case (ins[6:0])
            riscvPkg::opR: begin
                wr = 1'b1;
                res = aluRef(f3, ins[30], a, b);
            end
            riscvPkg::opImm: begin
                wr = 1'b1;
                res = aluRef(f3, ins[30] && f3 == 3'b101, a, immI);   // Only SRAI alternates
            end
            riscvPkg::opLui: begin
                wr = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            riscvPkg::opAuipc: begin
                wr = 1'b1;
                res = mPc + {ins[31:12], 12'b0};
            end
            riscvPkg::opLoad: begin
                wr = 1'b1;
                addr = a + immI;
                res = loadRef(f3, addr[1:0], mMem[addr[9:2]]);
            end
            riscvPkg::opStore: begin
                addr = a + immS;
                case (f3[1:0])
                2'b00: mMem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
                2'b01: mMem[addr[9:2]][{addr[1], 4'b0000} +: 16] = b[15:0];
                default: mMem[addr[9:2]] = b;
                endcase
            end
            riscvPkg::opBranch: if (branchRef(f3, a, b)) nextPc = mPc + immB;
            riscvPkg::opJal: begin
                wr = 1'b1;
                res = mPc + 32'd4;
                nextPc = mPc + immJ;
            end
            riscvPkg::opJalr: begin
                wr = 1'b1;
                res = mPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            default: begin   // Unknown opcode
            end
            endcase
            wr = wr && (ins[11:7] != 5'd0);

            checkField("pc", mPc, retire.pc);
            checkField("instr", ins, retire.instr);
            checkField("rd", {27'b0, ins[11:7]}, {27'b0, retire.rd});
            checkField("regWrite", {31'b0, wr}, {31'b0, retire.regWrite});
            if (wr) checkField("rdData", res, retire.rdData);

            if (recordRun) goldRun.push_back(retire);
            if (compareRun) begin
                if (runIdx >= goldRun.size()) begin
                    $display("retire sequence is longer than the zero-delay run");
                    testErrors++;
                end else if (goldRun[runIdx] !== retire) begin
                    $display("Mismatch test %0d retire record: expected %h actual %h",
                             testNo, goldRun[runIdx], retire);
                    testErrors++;
                end
                runIdx++;
            end

            if (wr) mRegs[ins[11:7]] = res;
            mPc = nextPc;
            retired++;

            if (ins == 32'h0000_006f) begin   // Final self-jump
                if (compareRun && runIdx != goldRun.size()) begin
                    $display("retire sequence is shorter than the zero-delay run");
                    testErrors++;
                end
                $display("test %0d: %0d instructions retired, %0d errors, %s", testNo,
                         retired, testErrors, (testErrors == 0) ? "pass" : "fail");
                if (testErrors == 0) begin
                    passCount <= passCount + 1;
                end else begin
                    failCount <= failCount + 1;
                end
                testNo++;
                testDone <= 1'b1;
            end
        end
    end

endmodule

//--- src/riscvCore.sv
// Multicycle RV32I core
`timescale 1ns/1ps

module riscvCore (
    input  logic                clk,
    input  logic                reset,
    output logic                fetchReq,
    output riscvPkg::fetchReqT  fetchAddr,
    input  logic                fetchAck,
    input  riscvPkg::fetchRspT  fetchData,
    output logic                dataReq,
    output riscvPkg::dataReqT   dataBits,
    input  logic                dataAck,
    input  riscvPkg::dataRspT   dataRsp,
    output logic                retireValid,
    output riscvPkg::retireT    retire
);

    logic [31:0]        pc;
    logic [31:0]        pcPlus4;
    logic [31:0]        target;
    riscvPkg::fetchRspT instr;
    logic [31:0]        imm;
    logic [31:0]        rs1Data;
    logic [31:0]        rs2Data;
    logic [31:0]        srcA;
    logic [31:0]        srcB;
    logic [31:0]        aluResult;
    logic [31:0]        aluOut;
    logic [31:0]        loadData;
    logic [31:0]        result;
    riscvPkg::dataRspT  dataWord;
    riscvPkg::ctrlT     ctrl;
    riscvPkg::dataReqT  alignReq;
    riscvPkg::dataReqT  dataPayload;
    logic               branchTaken;
    logic               fetchStart;
    logic               fetchDone;
    logic               dataStart;
    logic               dataDone;
    logic               regWriteEn;
    logic               pcWriteEn;

    controlUnit controlUnit_i (
        .clk, .reset, .instr, .branchTaken, .fetchDone, .dataDone,
        .fetchStart, .dataStart, .ctrl, .regWriteEn, .pcWriteEn, .retireValid
    );

    regFile regFile_i (
        .clk, .reset,
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
        .writeEn(regWriteEn), .rdData(result), .rs1Data, .rs2Data
    );

    immExtend immExtend_i (.instr, .kind(ctrl.immKind), .imm);

    assign srcA = ctrl.aluSrcA ? pc : rs1Data;
    assign srcB = ctrl.aluSrcB ? imm : rs2Data;

    alu alu_i (
        .a(srcA), .b(srcB), .op(ctrl.aluOp), .funct3(instr[14:12]),
        .result(aluResult), .branchTaken
    );

    // Operands hold from execute through writeback
    always_ff @(posedge clk) begin
        aluOut <= aluResult;
    end

    loadStoreAligner aligner_i (
        .addr(aluOut), .funct3(instr[14:12]), .storeData(rs2Data),
        .readWord(dataWord), .req(alignReq), .loadData
    );

    always_comb begin
        dataPayload = alignReq;
        dataPayload.write = ctrl.memWrite;
    end

    busPort #(.reqT(riscvPkg::fetchReqT), .rspT(riscvPkg::fetchRspT)) fetchPort_i (
        .clk, .reset, .start(fetchStart), .payload(pc), .req(fetchReq),
        .reqBits(fetchAddr), .ack(fetchAck), .rspBits(fetchData), .rsp(instr),
        .done(fetchDone)
    );

    busPort #(.reqT(riscvPkg::dataReqT), .rspT(riscvPkg::dataRspT)) dataPort_i (
        .clk, .reset, .start(dataStart), .payload(dataPayload), .req(dataReq),
        .reqBits(dataBits), .ack(dataAck), .rspBits(dataRsp), .rsp(dataWord),
        .done(dataDone)
    );

    always_comb begin
        case (ctrl.resultSrc)
        riscvPkg::resultLoad:    result = loadData;
        riscvPkg::resultPcPlus4: result = pcPlus4;
        default:                 result = aluOut;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;
    assign target  = ctrl.jump ? {aluOut[31:1], 1'b0} : pc + imm;   // Jumps use alu sum

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= riscvPkg::resetPc;
        end else if (retireValid) begin
            pc <= pcWriteEn ? target : pcPlus4;
        end
    end

    always_comb begin
        retire.pc       = pc;
        retire.instr    = instr;
        retire.rd       = instr[11:7];
        retire.rdData   = result;
        retire.regWrite = regWriteEn && (instr[11:7] != 5'd0);
    end

endmodule

//--- src/busPort.sv
// Four-phase req/ack requester
`timescale 1ns/1ps

module busPort #(
    parameter type reqT = logic [31:0],
    parameter type rspT = logic [31:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  reqT  payload,
    output logic req,
    output reqT  reqBits,
    input  logic ack,
    input  rspT  rspBits,
    output rspT  rsp,
    output logic done
);

    typedef enum logic [1:0] {stIdle, stWaitAck, stWaitRelease} stateT;

    stateT state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            req <= 1'b0;
        end else begin
            case (state)
            stIdle: begin
                if (start) begin
                    req <= 1'b1;
                    state <= stWaitAck;
                end
            end
            stWaitAck: begin
                if (ack) begin
                    req <= 1'b0;
                    state <= stWaitRelease;
                end
            end
            default: if (!ack) state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && start) reqBits <= payload;
        if (state == stWaitAck && ack) rsp <= rspBits;   // Held until next transfer
    end

    assign done = (state == stWaitRelease) && !ack;

    assert property (@(posedge clk) disable iff (reset)
        (req && !ack) |=> $stable(reqBits));

    assert property (@(posedge clk) disable iff (reset) $rose(req) |-> !ack);

endmodule

//--- src/loadStoreAligner.sv
// Load and store lane alignment
`timescale 1ns/1ps

module loadStoreAligner (
    input  logic [31:0]       addr,
    input  logic [2:0]        funct3,
    input  logic [31:0]       storeData,
    input  logic [31:0]       readWord,
    output riscvPkg::dataReqT req,
    output logic [31:0]       loadData
);

    logic [1:0]  offset;
    logic [31:0] byteLane;
    logic [15:0] halfLane;

    assign offset = addr[1:0];

    always_comb begin
        req.addr  = {addr[31:2], 2'b00};
        req.write = 1'b0;   // Set by the core
        case (funct3[1:0])
        2'b00: begin
            req.writeData = {4{storeData[7:0]}};
            req.byteEn    = 4'b0001 << offset;
        end
        2'b01: begin
            req.writeData = {2{storeData[15:0]}};
            req.byteEn    = offset[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
            req.writeData = storeData;
            req.byteEn    = 4'b1111;
        end
        endcase
    end

    assign byteLane = readWord >> {offset, 3'b000};
    assign halfLane = offset[1] ? readWord[31:16] : readWord[15:0];

    // funct3[2] selects zero extension
    always_comb begin
        case (funct3[1:0])
        2'b00: begin
            loadData = funct3[2] ? {24'b0, byteLane[7:0]}
                                 : {{24{byteLane[7]}}, byteLane[7:0]};
        end
        2'b01: begin
            loadData = funct3[2] ? {16'b0, halfLane} : {{16{halfLane[15]}}, halfLane};
        end
        default: loadData = readWord;
        endcase
    end

endmodule

//--- src/immExtend.sv
// Immediate generator
`timescale 1ns/1ps

module immExtend (
    input  logic [31:0]       instr,
    input  riscvPkg::immKindT kind,
    output logic [31:0]       imm
);

    always_comb begin
        case (kind)
        riscvPkg::immS: begin
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        end
        riscvPkg::immB: begin
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end
        riscvPkg::immJ: begin
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        end
        riscvPkg::immU: begin
            imm = {instr[31:12], 12'b0};
        end
        default: begin // I format
            imm = {{20{instr[31]}}, instr[31:20]};
        end
        endcase
    end

endmodule

//--- src/alu.sv
// ALU and branch compare
`timescale 1ns/1ps

module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  riscvPkg::aluOpT op,
    input  logic [2:0]      funct3,
    output logic [31:0]     result,
    output logic            branchTaken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
        riscvPkg::aluSub:   result = a - b;
        riscvPkg::aluSll:   result = a << shamt;
        riscvPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
        riscvPkg::aluSltu:  result = {31'b0, a < b};
        riscvPkg::aluXor:   result = a ^ b;
        riscvPkg::aluSrl:   result = a >> shamt;
        riscvPkg::aluSra:   result = $signed(a) >>> shamt;
        riscvPkg::aluOr:    result = a | b;
        riscvPkg::aluAnd:   result = a & b;
        riscvPkg::aluPassB: result = b;
        default:            result = a + b;
        endcase
    end

    always_comb begin
        case (funct3)
        3'b000:  branchTaken = (a == b);                    // BEQ
        3'b001:  branchTaken = (a != b);
        3'b100:  branchTaken = ($signed(a) < $signed(b));   // BLT
        3'b101:  branchTaken = ($signed(a) >= $signed(b));
        3'b110:  branchTaken = (a < b);                     // BLTU
        3'b111:  branchTaken = (a >= b);
        default: branchTaken = 1'b0;
        endcase
    end

endmodule

//--- src/regFile.sv
// Integer register file
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic        writeEn,
    input  logic [31:0] rdData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [1:31];   // No storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

//--- src/controlUnit.sv
// Instruction sequencer and decoders
`timescale 1ns/1ps

module controlUnit (
    input  logic           clk,
    input  logic           reset,
    input  logic [31:0]    instr,
    input  logic           branchTaken,
    input  logic           fetchDone,
    input  logic           dataDone,
    output logic           fetchStart,
    output logic           dataStart,
    output riscvPkg::ctrlT ctrl,
    output logic           regWriteEn,
    output logic           pcWriteEn,
    output logic           retireValid
);

    typedef enum logic [1:0] {stFetch, stExec, stMem, stWb} stateT;

    stateT           state;
    logic            busy;          // Bus transfer in flight
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7b5;
    logic [1:0]      aluClass;
    riscvPkg::ctrlT  decCtrl;
    riscvPkg::aluOpT aluOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // Main decoder
    always_comb begin
        decCtrl.regWrite  = 1'b0;
        decCtrl.memWrite  = 1'b0;
        decCtrl.memAccess = 1'b0;
        decCtrl.branch    = 1'b0;
        decCtrl.jump      = 1'b0;
        decCtrl.aluSrcA   = 1'b0;
        decCtrl.aluSrcB   = 1'b0;
        decCtrl.resultSrc = riscvPkg::resultAlu;
        decCtrl.immKind   = riscvPkg::immI;
        decCtrl.aluOp     = riscvPkg::aluAdd;
        aluClass          = 2'b00;
        case (opcode)
        riscvPkg::opR: begin // R-type
            decCtrl.regWrite = 1'b1;
            aluClass = 2'b10;
        end
        riscvPkg::opImm: begin // I-type ALU
            decCtrl.regWrite = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            aluClass = 2'b11;
        end
        riscvPkg::opLoad: begin
            decCtrl.regWrite = 1'b1;
            decCtrl.memAccess = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.resultSrc = riscvPkg::resultLoad;
        end
        riscvPkg::opStore: begin
            decCtrl.memWrite = 1'b1;
            decCtrl.memAccess = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.immKind = riscvPkg::immS;
        end
        riscvPkg::opBranch: begin // Compares rs1 with rs2
            decCtrl.branch = 1'b1;
            decCtrl.immKind = riscvPkg::immB;
        end
        riscvPkg::opJal: begin // Alu forms pc + imm
            decCtrl.regWrite = 1'b1;
            decCtrl.jump = 1'b1;
            decCtrl.aluSrcA = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.resultSrc = riscvPkg::resultPcPlus4;
            decCtrl.immKind = riscvPkg::immJ;
        end
        riscvPkg::opJalr: begin
            decCtrl.regWrite = 1'b1;
            decCtrl.jump = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.resultSrc = riscvPkg::resultPcPlus4;
        end
        riscvPkg::opLui: begin
            decCtrl.regWrite = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.immKind = riscvPkg::immU;
            aluClass = 2'b01;
        end
        riscvPkg::opAuipc: begin
            decCtrl.regWrite = 1'b1;
            decCtrl.aluSrcA = 1'b1;
            decCtrl.aluSrcB = 1'b1;
            decCtrl.immKind = riscvPkg::immU;
        end
        default: begin // Unknown opcode, no-op
        end
        endcase
    end

    // ALU decoder
    always_comb begin
        case (aluClass)
        2'b00: aluOp = riscvPkg::aluAdd;
        2'b01: aluOp = riscvPkg::aluPassB;
        default: begin
            case (funct3)
            3'b000: begin
                aluOp = (aluClass == 2'b10 && funct7b5) ? riscvPkg::aluSub
                                                        : riscvPkg::aluAdd;
            end
            3'b001: aluOp = riscvPkg::aluSll;
            3'b010: aluOp = riscvPkg::aluSlt;
            3'b011: aluOp = riscvPkg::aluSltu;
            3'b100: aluOp = riscvPkg::aluXor;
            3'b101: aluOp = funct7b5 ? riscvPkg::aluSra : riscvPkg::aluSrl;
            3'b110: aluOp = riscvPkg::aluOr;
            default: aluOp = riscvPkg::aluAnd;
            endcase
        end
        endcase
    end

    always_comb begin
        ctrl = decCtrl;
        ctrl.aluOp = aluOp;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            busy <= 1'b0;
        end else begin
            if (fetchStart || dataStart) begin
                busy <= 1'b1;
            end else if (fetchDone || dataDone) begin
                busy <= 1'b0;
            end
            case (state)
            stFetch: if (fetchDone) state <= stExec;
            stExec: state <= decCtrl.memAccess ? stMem : stWb;
            stMem: if (dataDone) state <= stWb;
            default: state <= stFetch;
            endcase
        end
    end

    assign fetchStart  = (state == stFetch) && !busy;
    assign dataStart   = (state == stMem) && !busy;
    assign retireValid = (state == stWb);
    assign regWriteEn  = retireValid && decCtrl.regWrite;
    // Load branch or jump target
    assign pcWriteEn   = retireValid && (decCtrl.jump || (decCtrl.branch && branchTaken));

    assert property (@(posedge clk) disable iff (reset)
        !($rose(fetchStart) && $rose(dataStart)));

endmodule

//--- src/riscvPkg.sv
// RV32I core shared definitions
package riscvPkg;

    // Major opcodes
    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal   = 7'b1101111;
    localparam logic [6:0] opJalr  = 7'b1100111;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    localparam logic [31:0] resetPc = 32'h0000_0000;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB    // LUI
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immJ,
        immU
    } immKindT;

    typedef enum logic [1:0] {
        resultAlu,
        resultLoad,
        resultPcPlus4
    } resultSrcT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      memAccess;   // Load or store
        logic      branch;
        logic      jump;
        logic      aluSrcA;     // Pc as operand a
        logic      aluSrcB;     // Immediate as operand b
        resultSrcT resultSrc;
        immKindT   immKind;
        aluOpT     aluOp;
    } ctrlT;

    typedef logic [31:0] fetchReqT;
    typedef logic [31:0] fetchRspT;

    typedef struct packed {
        logic [31:0] addr;      // Word aligned
        logic [31:0] writeData;
        logic [3:0]  byteEn;
        logic        write;
    } dataReqT;

    typedef logic [31:0] dataRspT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [31:0] rdData;
        logic        regWrite;
    } retireT;

endpackage
